//--- Bender.yml
package:
  name: ifm_chunk

sources:
  - hdl/ifm_chunk_pkg.sv
  - hdl/chunk_buffer.sv
  - hdl/sparsemap_window.sv
  - hdl/chunk_pingpong.sv
  - hdl/ifm_chunk_top.sv
  - target: test
    files:
      - dv/ifm_chunk_tb.sv

//--- compile.f
hdl/ifm_chunk_pkg.sv
hdl/chunk_buffer.sv
hdl/sparsemap_window.sv
hdl/chunk_pingpong.sv
hdl/ifm_chunk_top.sv
dv/ifm_chunk_tb.sv

//--- dv/ifm_chunk_tb.sv
`timescale 1ns/10ps

module ifm_chunk_tb;

	localparam int CU_NUM = 4;
	localparam int BUS_SIZE = ifm_chunk_pkg::BUS_SIZE;
	localparam int MEM_SIZE = ifm_chunk_pkg::MEM_SIZE;
	localparam int SEG_W = ifm_chunk_pkg::PREFIX_SUM_SIZE;
	localparam int WR_BEAT_NUM = ifm_chunk_pkg::WR_BEAT_NUM;
	localparam int WIN_NUM = ifm_chunk_pkg::WIN_NUM;
	localparam int DATA_W = ifm_chunk_pkg::DATA_W;
	localparam int DATA_ADDR_W = ifm_chunk_pkg::DATA_ADDR_W;
	localparam int WIN_ADDR_W = ifm_chunk_pkg::WIN_ADDR_W;
	localparam int SHIFT_W = ifm_chunk_pkg::SHIFT_W;
	localparam int COUNT_W = ifm_chunk_pkg::COUNT_W;
	// Generous bound over the length of all tests
	localparam int MAX_CYCLES = 2000;

	logic                                   clk_i;
	logic                                   rst_i;
	ifm_chunk_pkg::wr_beat_t                wr_beat_i;
	logic                                   wr_valid_i;
	logic                                   wr_sel_i;
	logic                                   rd_sel_i;
	logic                                   chunk_start_i;
	ifm_chunk_pkg::cu_rd_req_t [CU_NUM-1:0] rd_req_i;
	ifm_chunk_pkg::cu_rd_rsp_t [CU_NUM-1:0] rd_rsp_o;

	// Reference banks, packed bytes indexed by compacted index
	logic [MEM_SIZE-1:0] ref_map [2];
	logic [DATA_W-1:0]   ref_data [2][MEM_SIZE+1];
	int                  ref_fill [2];
	int                  ref_used [2];

	integer seed;
	int     cycle_cnt = 0;

	ifm_chunk_top #(
		.CU_NUM (CU_NUM)
	) u_ifm_chunk_top (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.wr_beat_i     (wr_beat_i),
		.wr_valid_i    (wr_valid_i),
		.wr_sel_i      (wr_sel_i),
		.rd_sel_i      (rd_sel_i),
		.chunk_start_i (chunk_start_i),
		.rd_req_i      (rd_req_i),
		.rd_rsp_o      (rd_rsp_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, tests did not finish", cycle_cnt);
			$display("=== FAIL ===");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Applies the beat captured on this edge
	task automatic update_model();
		int bank;
		int pop;
		int base;
		if (wr_valid_i) begin
			bank = int'(wr_sel_i);
			base = int'(wr_beat_i.count) * BUS_SIZE;
			ref_map[bank][base +: BUS_SIZE] = wr_beat_i.sparsemap;
			if (wr_beat_i.count == '0) begin
				ref_fill[bank] = 1;
				ref_used[bank] = 0;
			end
			pop = $countones(wr_beat_i.sparsemap);
			for (int i = 0; i < pop; i++) begin
				ref_data[bank][ref_fill[bank]] = wr_beat_i.nonzero_data[i];
				ref_fill[bank] = (ref_fill[bank] == MEM_SIZE) ? 1 : ref_fill[bank] + 1;
			end
			ref_used[bank] = ref_used[bank] + pop;
			if (ref_used[bank] > MEM_SIZE) begin
				ref_used[bank] = MEM_SIZE;
			end
		end
	endtask

	function automatic logic [DATA_W-1:0] expect_data(input int bank, input int addr);
		if (addr == 0) begin
			return '0;
		end
		return ref_data[bank][addr];
	endfunction

	// Segment k low, segment k+1 or zero high, then shifted down
	function automatic logic [SEG_W-1:0] expect_window(input int bank, input int win,
		input int shift);
		logic [2*SEG_W-1:0] pair;
		pair[SEG_W-1:0] = ref_map[bank][win*SEG_W +: SEG_W];
		if (win == WIN_NUM - 1) begin
			pair[2*SEG_W-1:SEG_W] = '0;
		end else begin
			pair[2*SEG_W-1:SEG_W] = ref_map[bank][(win+1)*SEG_W +: SEG_W];
		end
		pair = pair >> shift;
		return pair[SEG_W-1:0];
	endfunction

	// Highest index filled in both banks
	function automatic int min_used();
		return (ref_used[0] < ref_used[1]) ? ref_used[0] : ref_used[1];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Drivers and checks
	//////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk_i);
		update_model();
		wr_valid_i <= 1'b0;
		chunk_start_i <= 1'b0;
	endtask

	task automatic write_beat(input int bank, input int idx);
		ifm_chunk_pkg::wr_beat_t beat;
		logic [31:0]             rnd;
		rnd = $random(seed);
		beat.sparsemap = rnd[BUS_SIZE-1:0];
		// First beat always carries index 1
		if (idx == 0) begin
			beat.sparsemap[0] = 1'b1;
		end
		for (int i = 0; i < BUS_SIZE; i++) begin
			rnd = $random(seed);
			beat.nonzero_data[i] = rnd[DATA_W-1:0];
		end
		beat.count = idx[COUNT_W-1:0];
		wr_beat_i <= beat;
		wr_valid_i <= 1'b1;
		wr_sel_i <= bank[0];
	endtask

	task automatic start_bank(input int bank);
		chunk_start_i <= 1'b1;
		rd_sel_i <= bank[0];
	endtask

	// Units in last_mask request the last window with pri_enc_last
	task automatic set_reads(input int addr_base, input int limit, input int win_base,
		input int shift, input logic [CU_NUM-1:0] last_mask);
		ifm_chunk_pkg::cu_rd_req_t req;
		int                        addr;
		int                        win;
		for (int u = 0; u < CU_NUM; u++) begin
			addr = (addr_base + u) % (limit + 1);
			win = (win_base + u) % WIN_NUM;
			if (last_mask[u]) begin
				win = WIN_NUM - 1;
			end
			req.data_addr = addr[DATA_ADDR_W-1:0];
			req.win_addr = win[WIN_ADDR_W-1:0];
			req.shift = shift[SHIFT_W-1:0];
			req.pri_enc_last = last_mask[u];
			rd_req_i[u] <= req;
		end
	endtask

	task automatic check_data(input string test_name, input int unit,
		input logic [DATA_W-1:0] expected, input logic [DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("Fail %s unit %0d data: expected %h actual %h",
				test_name, unit, expected, actual);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	task automatic check_window(input string test_name, input int unit,
		input logic [SEG_W-1:0] expected, input logic [SEG_W-1:0] actual);
		if (actual !== expected) begin
			$display("Fail %s unit %0d window: expected %b actual %b",
				test_name, unit, expected, actual);
			$display("=== FAIL ===");
			$fatal(1);
		end
	endtask

	// Outputs are sampled mid-cycle, banks gives each unit's expected bank
	task automatic check_units(input string test_name, input logic [CU_NUM-1:0] banks);
		ifm_chunk_pkg::cu_rd_req_t req;
		int                        bank;
		@(negedge clk_i);
		for (int u = 0; u < CU_NUM; u++) begin
			req = rd_req_i[u];
			bank = int'(banks[u]);
			check_data(test_name, u, expect_data(bank, int'(req.data_addr)), rd_rsp_o[u].data);
			check_window(test_name, u,
				expect_window(bank, int'(req.win_addr), int'(req.shift)), rd_rsp_o[u].window);
		end
	endtask

	task automatic sweep_data(input string test_name, input int bank);
		for (int a = 0; a <= ref_used[bank]; a += CU_NUM) begin
			tick();
			set_reads(a, ref_used[bank], a / CU_NUM, 0, '0);
			check_units(test_name, {CU_NUM{bank[0]}});
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_write_read_bank0();
		for (int b = 0; b < WR_BEAT_NUM; b++) begin
			tick();
			write_beat(0, b);
		end
		tick();
		start_bank(0);
		set_reads(0, ref_used[0], 0, 0, '0);
		check_units("test_write_read_bank0", '0);
		sweep_data("test_write_read_bank0", 0);
	endtask

	task automatic test_window_shift();
		for (int w = 0; w < WIN_NUM; w++) begin
			for (int s = 0; s < SEG_W; s++) begin
				tick();
				set_reads(w + s, ref_used[0], w, s, '0);
				check_units("test_window_shift", '0);
			end
		end
	endtask

	task automatic test_pingpong_overlap();
		// Bank 1 fills while every unit reads bank 0
		for (int b = 0; b < WR_BEAT_NUM; b++) begin
			tick();
			write_beat(1, b);
			set_reads(b * CU_NUM, ref_used[0], b, b, '0);
			check_units("test_pingpong_overlap", '0);
		end
		tick();
		start_bank(1);
		set_reads(0, ref_used[1], 0, 0, '0);
		check_units("test_pingpong_overlap", '1);
		sweep_data("test_pingpong_overlap", 1);
	endtask

	task automatic test_per_unit_flip();
		tick();
		start_bank(0);
		set_reads(1, min_used(), 0, 0, '0);
		check_units("test_per_unit_flip", '0);
		tick();
		set_reads(2, min_used(), 0, 0, 4'b1010);
		check_units("test_per_unit_flip", '0);
		tick();
		set_reads(3, min_used(), 1, 0, '0);
		check_units("test_per_unit_flip", 4'b1010);
		tick();
		set_reads(5, min_used(), 2, 3, '0);
		check_units("test_per_unit_flip", 4'b1010);
	endtask

	task automatic test_chunk_restart();
		// Chunk start pulls units 1 and 3 back to bank 0
		tick();
		start_bank(0);
		set_reads(0, min_used(), 0, 0, '0);
		check_units("test_chunk_restart", '0);
		tick();
		set_reads(4, min_used(), 1, 1, '0);
		check_units("test_chunk_restart", '0);
		for (int b = 0; b < WR_BEAT_NUM; b++) begin
			tick();
			write_beat(1, b);
			set_reads(b * CU_NUM, ref_used[0], b, 2, '0);
			check_units("test_chunk_restart", '0);
		end
		tick();
		start_bank(1);
		set_reads(0, ref_used[1], 0, 0, '0);
		check_units("test_chunk_restart", '1);
		sweep_data("test_chunk_restart", 1);
	endtask

	initial begin
		seed = 32'h5d48e742;
		rst_i = 1'b1;
		wr_beat_i = '0;
		wr_valid_i = 1'b0;
		wr_sel_i = 1'b0;
		rd_sel_i = 1'b0;
		chunk_start_i = 1'b0;
		rd_req_i = '0;
		for (int b = 0; b < 2; b++) begin
			ref_map[b] = '0;
			ref_fill[b] = 1;
			ref_used[b] = 0;
		end
		repeat (8) @(posedge clk_i);
		rst_i <= 1'b0;
		test_write_read_bank0();
		test_window_shift();
		test_pingpong_overlap();
		test_per_unit_flip();
		test_chunk_restart();
		tick();
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- hdl/chunk_buffer.sv
`timescale 1ns/10ps

module chunk_buffer (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  ifm_chunk_pkg::wr_beat_t             wr_beat_i,
	input  logic                                wr_valid_i,
	output logic [ifm_chunk_pkg::MEM_SIZE-1:0]  sparsemap_o,
	output logic [ifm_chunk_pkg::MEM_SIZE-1:0][ifm_chunk_pkg::DATA_W-1:0] nonzero_data_o
);

	localparam int BUS_SIZE = ifm_chunk_pkg::BUS_SIZE;
	localparam int MEM_SIZE = ifm_chunk_pkg::MEM_SIZE;
	localparam int DATA_W = ifm_chunk_pkg::DATA_W;
	localparam int PTR_W = ifm_chunk_pkg::PTR_W;
	// Enough bits to count every position of a beat
	localparam int CNT_W = $clog2(BUS_SIZE + 1);

	logic [MEM_SIZE-1:0]             sparsemap_q;
	logic [MEM_SIZE-1:0][DATA_W-1:0] data_q;

	// Slot 0 holds compacted index 1
	logic [PTR_W-1:0]                fill_ptr_q;
	logic [PTR_W-1:0]                fill_ptr_d;
	logic [PTR_W-1:0]                base_ptr;
	logic [CNT_W-1:0]                nz_count;
	logic [BUS_SIZE-1:0][PTR_W-1:0]  wr_slot;
	logic [BUS_SIZE-1:0]             wr_lane_en;

	// Slot position modulo the chunk size
	function automatic logic [PTR_W-1:0] wrap_ptr(input int pos);
		int wrapped;
		wrapped = pos;
		if (wrapped >= MEM_SIZE) begin
			wrapped = wrapped - MEM_SIZE;
		end
		return PTR_W'(wrapped);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Packing control
	//////////////////////////////////////////////////////////////////////

	// Number of nonzero bytes carried by the beat
	always_comb begin
		nz_count = '0;
		for (int i = 0; i < BUS_SIZE; i++) begin
			nz_count = nz_count + CNT_W'(wr_beat_i.sparsemap[i]);
		end
	end

	// First beat of a chunk restarts packing at index 1
	assign base_ptr = (wr_beat_i.count == '0) ? '0 : fill_ptr_q;

	// Destination slot of each beat lane
	always_comb begin
		for (int i = 0; i < BUS_SIZE; i++) begin
			wr_slot[i] = wrap_ptr(int'(base_ptr) + i);
			wr_lane_en[i] = (i < int'(nz_count));
		end
	end

	assign fill_ptr_d = wrap_ptr(int'(base_ptr) + int'(nz_count));

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			fill_ptr_q <= '0;
		end else if (wr_valid_i) begin
			fill_ptr_q <= fill_ptr_d;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	// Sparsemap slice lands at its beat position
	always_ff @(posedge clk_i) begin
		if (wr_valid_i) begin
			sparsemap_q[wr_beat_i.count * BUS_SIZE +: BUS_SIZE] <= wr_beat_i.sparsemap;
		end
	end

	// Only the leading nonzero lanes are appended
	always_ff @(posedge clk_i) begin
		if (wr_valid_i) begin
			for (int i = 0; i < BUS_SIZE; i++) begin
				if (wr_lane_en[i]) begin
					data_q[wr_slot[i]] <= wr_beat_i.nonzero_data[i];
				end
			end
		end
	end

	// Flat registers, every unit reads in parallel
	assign sparsemap_o = sparsemap_q;
	assign nonzero_data_o = data_q;

endmodule

//--- hdl/chunk_pingpong.sv
`timescale 1ns/10ps

module chunk_pingpong #(
	parameter int CU_NUM = 4
) (
	input  logic                                    clk_i,
	input  logic                                    rst_i,

	// Write port
	input  ifm_chunk_pkg::wr_beat_t                 wr_beat_i,
	input  logic                                    wr_valid_i,
	input  logic                                    wr_sel_i,

	// Read control shared by all units
	input  logic                                    rd_sel_i,
	input  logic                                    chunk_start_i,

	// Per-unit read ports
	input  ifm_chunk_pkg::cu_rd_req_t [CU_NUM-1:0]  rd_req_i,
	output ifm_chunk_pkg::cu_rd_rsp_t [CU_NUM-1:0]  rd_rsp_o
);

	localparam int MEM_SIZE = ifm_chunk_pkg::MEM_SIZE;
	localparam int DATA_W = ifm_chunk_pkg::DATA_W;
	localparam int PREFIX_SUM_SIZE = ifm_chunk_pkg::PREFIX_SUM_SIZE;
	localparam int WIN_NUM = ifm_chunk_pkg::WIN_NUM;
	localparam int WIN_ADDR_W = ifm_chunk_pkg::WIN_ADDR_W;
	localparam int DATA_ADDR_W = ifm_chunk_pkg::DATA_ADDR_W;
	localparam int PTR_W = ifm_chunk_pkg::PTR_W;

	logic [1:0]                             bank_wr_valid;
	logic [1:0][MEM_SIZE-1:0]               bank_map;
	logic [1:0][MEM_SIZE-1:0][DATA_W-1:0]   bank_data;

	logic [CU_NUM-1:0]                      sel_q;
	logic [CU_NUM-1:0]                      sel_eff;
	logic [CU_NUM-1:0]                      unit_last;
	logic [CU_NUM-1:0][MEM_SIZE-1:0]        unit_map;
	logic [CU_NUM-1:0][PREFIX_SUM_SIZE-1:0] unit_window;
	logic [CU_NUM-1:0][PTR_W-1:0]           data_slot;
	logic [CU_NUM-1:0][DATA_W-1:0]          unit_data;

	//////////////////////////////////////////////////////////////////////
	// Bank pair
	//////////////////////////////////////////////////////////////////////

	for (genvar b = 0; b < 2; b++) begin : g_bank
		// Only the selected bank takes the beat
		assign bank_wr_valid[b] = wr_valid_i && (wr_sel_i == 1'(b));

		chunk_buffer u_chunk_buffer (
			.clk_i          (clk_i),
			.rst_i          (rst_i),
			.wr_beat_i      (wr_beat_i),
			.wr_valid_i     (bank_wr_valid[b]),
			.sparsemap_o    (bank_map[b]),
			.nonzero_data_o (bank_data[b])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Per-unit bank tracking
	//////////////////////////////////////////////////////////////////////

	// Chunk start overrides every stored bit
	assign sel_eff = chunk_start_i ? {CU_NUM{rd_sel_i}} : sel_q;

	always_comb begin
		for (int u = 0; u < CU_NUM; u++) begin
			unit_last[u] = (rd_req_i[u].win_addr == WIN_ADDR_W'(WIN_NUM - 1)) &&
				rd_req_i[u].pri_enc_last;
		end
	end

	// Unit done with its last window moves to the other bank
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sel_q <= '0;
		end else begin
			for (int u = 0; u < CU_NUM; u++) begin
				if (unit_last[u]) begin
					sel_q[u] <= ~rd_sel_i;
				end else begin
					sel_q[u] <= sel_eff[u];
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read multiplexing
	//////////////////////////////////////////////////////////////////////

	for (genvar u = 0; u < CU_NUM; u++) begin : g_unit
		assign unit_map[u] = bank_map[sel_eff[u]];

		sparsemap_window u_sparsemap_window (
			.sparsemap_i (unit_map[u]),
			.win_addr_i  (rd_req_i[u].win_addr),
			.shift_i     (rd_req_i[u].shift),
			.window_o    (unit_window[u])
		);
	end

	// Index 1 lives in slot 0
	always_comb begin
		for (int u = 0; u < CU_NUM; u++) begin
			data_slot[u] = PTR_W'(rd_req_i[u].data_addr - DATA_ADDR_W'(1));
			if (rd_req_i[u].data_addr == '0) begin
				unit_data[u] = '0;
			end else begin
				unit_data[u] = bank_data[sel_eff[u]][data_slot[u]];
			end
		end
	end

	always_comb begin
		for (int u = 0; u < CU_NUM; u++) begin
			rd_rsp_o[u].data = unit_data[u];
			rd_rsp_o[u].window = unit_window[u];
		end
	end

endmodule

//--- hdl/ifm_chunk_pkg.sv
package ifm_chunk_pkg;

	//////////////////////////////////////////////////////////////////////
	// Chunk geometry
	//////////////////////////////////////////////////////////////////////

	// Activation positions per write beat
	localparam int BUS_SIZE = 8;
	// Activation positions per chunk
	localparam int MEM_SIZE = 32;
	// Bits per sparsemap window seen by a compute unit
	localparam int PREFIX_SUM_SIZE = 8;
	localparam int WR_BEAT_NUM = MEM_SIZE / BUS_SIZE;
	localparam int WIN_NUM = MEM_SIZE / PREFIX_SUM_SIZE;
	localparam int DATA_W = 8;

	// Derived field widths
	localparam int COUNT_W = $clog2(WR_BEAT_NUM);
	localparam int DATA_ADDR_W = $clog2(MEM_SIZE) + 1;
	localparam int WIN_ADDR_W = $clog2(WIN_NUM);
	localparam int SHIFT_W = $clog2(PREFIX_SUM_SIZE);
	// Slot index into the packed byte store
	localparam int PTR_W = $clog2(MEM_SIZE);

	//////////////////////////////////////////////////////////////////////
	// Bus types
	//////////////////////////////////////////////////////////////////////

	// One write beat of a compressed chunk
	typedef struct packed {
		logic [BUS_SIZE-1:0]             sparsemap;
		// Nonzero bytes first, in position order
		logic [BUS_SIZE-1:0][DATA_W-1:0] nonzero_data;
		logic [COUNT_W-1:0]              count;
	} wr_beat_t;

	// Read request of one compute unit
	typedef struct packed {
		// Compacted index, 0 reads as zero
		logic [DATA_ADDR_W-1:0] data_addr;
		logic [WIN_ADDR_W-1:0]  win_addr;
		logic [SHIFT_W-1:0]     shift;
		logic                   pri_enc_last;
	} cu_rd_req_t;

	// Read response of one compute unit
	typedef struct packed {
		logic [DATA_W-1:0]          data;
		logic [PREFIX_SUM_SIZE-1:0] window;
	} cu_rd_rsp_t;

endpackage

//--- hdl/ifm_chunk_top.sv
`timescale 1ns/10ps

module ifm_chunk_top #(
	// Number of compute units reading the store
	parameter int CU_NUM = 4
) (
	input  logic                                    clk_i,
	input  logic                                    rst_i,

	//////////////////////////////////////////////////////////////////////
	// Producer side
	//////////////////////////////////////////////////////////////////////

	// One beat per strobe, count order within a chunk
	input  ifm_chunk_pkg::wr_beat_t                 wr_beat_i,
	input  logic                                    wr_valid_i,
	// Destination bank, held for a whole chunk
	input  logic                                    wr_sel_i,

	//////////////////////////////////////////////////////////////////////
	// Compute unit side
	//////////////////////////////////////////////////////////////////////

	// Bank adopted by all units while chunk_start_i is high
	input  logic                                    rd_sel_i,
	input  logic                                    chunk_start_i,

	// Zero-latency reads, one request per unit
	input  ifm_chunk_pkg::cu_rd_req_t [CU_NUM-1:0]  rd_req_i,
	output ifm_chunk_pkg::cu_rd_rsp_t [CU_NUM-1:0]  rd_rsp_o
);

	// Ping-pong store with per-unit bank tracking
	chunk_pingpong #(
		.CU_NUM (CU_NUM)
	) u_chunk_pingpong (
		.clk_i         (clk_i),
		.rst_i         (rst_i),

		// Write steering
		.wr_beat_i     (wr_beat_i),
		.wr_valid_i    (wr_valid_i),
		.wr_sel_i      (wr_sel_i),

		// Bank select
		.rd_sel_i      (rd_sel_i),
		.chunk_start_i (chunk_start_i),

		// Per-unit data and window
		.rd_req_i      (rd_req_i),
		.rd_rsp_o      (rd_rsp_o)
	);

endmodule

//--- hdl/sparsemap_window.sv
`timescale 1ns/10ps

module sparsemap_window (
	input  logic [ifm_chunk_pkg::MEM_SIZE-1:0]        sparsemap_i,
	input  logic [ifm_chunk_pkg::WIN_ADDR_W-1:0]      win_addr_i,
	input  logic [ifm_chunk_pkg::SHIFT_W-1:0]         shift_i,
	output logic [ifm_chunk_pkg::PREFIX_SUM_SIZE-1:0] window_o
);

	localparam int MEM_SIZE = ifm_chunk_pkg::MEM_SIZE;
	localparam int SEG_W = ifm_chunk_pkg::PREFIX_SUM_SIZE;
	localparam int WIN_NUM = ifm_chunk_pkg::WIN_NUM;
	localparam int WIN_ADDR_W = ifm_chunk_pkg::WIN_ADDR_W;

	// One zero segment above the chunk feeds the last window
	logic [MEM_SIZE+SEG_W-1:0] ext_map;
	logic [2*SEG_W-1:0]        seg_pair;
	logic [2*SEG_W-1:0]        seg_shifted;

	assign ext_map = {{SEG_W{1'b0}}, sparsemap_i};

	//////////////////////////////////////////////////////////////////////
	// Segment select
	//////////////////////////////////////////////////////////////////////

	// Segment k low, segment k+1 high
	always_comb begin
		seg_pair = '0;
		for (int k = 0; k < WIN_NUM; k++) begin
			if (win_addr_i == WIN_ADDR_W'(k)) begin
				seg_pair = ext_map[k*SEG_W +: 2*SEG_W];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sliding shift
	//////////////////////////////////////////////////////////////////////

	// Upper neighbour bits slide into the window
	assign seg_shifted = seg_pair >> shift_i;

	assign window_o = seg_shifted[SEG_W-1:0];

endmodule
